/* source/backup_pkg.sv */
/*
 * Save engine sizes, RAM type and FSM enums,
 * memory, sector buffer and SD command structs
 */

package backup_pkg;

	localparam int WORD_W          = 16;
	localparam int SECTOR_WORDS    = 256;
	localparam int WORD_ADDR_W     = 8;
	localparam int MAX_SECTORS_DEF = 8;
	localparam int SECTOR_W        = $clog2(MAX_SECTORS_DEF);
	localparam int MEM_ADDR_W      = SECTOR_W + WORD_ADDR_W;
	localparam int LBA_W           = 16;

	// Cartridge backup RAM size in sectors
	typedef enum logic [2:0] {
		RAM_NONE = 3'd0,
		RAM_1S   = 3'd1,
		RAM_2S   = 3'd2,
		RAM_4S   = 3'd3,
		RAM_8S   = 3'd4
	} ram_type_e;

	typedef struct packed {
		logic                  req;
		logic                  we;
		logic [MEM_ADDR_W-1:0] addr;
		logic [WORD_W-1:0]     wdata;
	} mem_req_t;

	typedef struct packed {
		logic              ready;
		logic [WORD_W-1:0] rdata;
	} mem_rsp_t;

	typedef struct packed {
		logic                   wr;
		logic [WORD_ADDR_W-1:0] addr;
		logic [WORD_W-1:0]      data;
	} buf_port_t;

	typedef struct packed {
		logic             rd;
		logic             wr;
		logic [LBA_W-1:0] lba;
	} sd_cmd_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SD_READ,
		ST_COPY_IN,
		ST_COPY_OUT,
		ST_SD_WRITE
	} seq_state_e;

	typedef enum logic [1:0] {
		CP_IDLE,
		CP_REQ,
		CP_WAIT,
		CP_DONE
	} copy_state_e;

endpackage

/* source/save_memory.sv */
/*
 * Battery-backed save RAM, single port, registered read
 */

`timescale 1ns/100ps

module save_memory #(
	parameter int MAX_SECTORS = backup_pkg::MAX_SECTORS_DEF
) (
	input  logic                          clk_sys,
	input  backup_pkg::mem_req_t          mem,
	output logic [backup_pkg::WORD_W-1:0] rdata
);

	localparam int DEPTH = MAX_SECTORS * backup_pkg::SECTOR_WORDS;
	localparam int AW    = $clog2(DEPTH);

	logic [backup_pkg::WORD_W-1:0] ram [DEPTH];
	logic [AW-1:0]                 index;

	assign index = mem.addr[AW-1:0];

	// Write takes the cycle, otherwise the addressed word shows up next cycle
	always_ff @(posedge clk_sys) begin
		if (mem.req && mem.we) begin
			ram[index] <= mem.wdata;
		end else begin
			rdata <= ram[index];
		end
	end

endmodule

/* source/mem_arbiter.sv */
/*
 * Save RAM arbiter, game port over sector copy engine,
 * grant tags route ready and read data back to the owner
 */

`timescale 1ns/100ps

module mem_arbiter #(
	parameter int MAX_SECTORS = backup_pkg::MAX_SECTORS_DEF
) (
	input  logic                          clk_sys,
	input  logic                          rst,
	input  backup_pkg::mem_req_t          game_req,
	output backup_pkg::mem_rsp_t          game_rsp,
	input  backup_pkg::mem_req_t          copy_req,
	output backup_pkg::mem_rsp_t          copy_rsp,
	output backup_pkg::mem_req_t          mem,
	input  logic [backup_pkg::WORD_W-1:0] mem_rdata
);

	localparam int DEPTH = MAX_SECTORS * backup_pkg::SECTOR_WORDS;

	backup_pkg::mem_req_t game_q;
	backup_pkg::mem_req_t copy_q;
	backup_pkg::mem_req_t sel;
	logic                 copy_pend;
	logic                 copy_issue;
	logic                 tag_game;
	logic                 tag_copy;

	////////////////////////////////////////////////////
	// Request capture

	// Game access always goes out one cycle after it arrives
	always_ff @(posedge clk_sys) begin
		game_q <= game_req;
		if (rst) begin
			game_q.req <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (copy_req.req) begin
			copy_q <= copy_req;
		end
	end

	// Held copy request waits while the game owns the port
	assign copy_issue = copy_pend && !game_q.req;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			copy_pend <= 1'b0;
		end else if (copy_req.req) begin
			copy_pend <= 1'b1;
		end else if (copy_issue) begin
			copy_pend <= 1'b0;
		end
	end

	////////////////////////////////////////////////////
	// Grant stage

	always_comb begin
		if (game_q.req) begin
			sel = game_q;
		end else begin
			sel     = copy_q;
			sel.req = copy_pend;
		end
		mem = sel;
		// Drop writes beyond the fitted RAM so they cannot alias
		mem.we = sel.we && (int'(sel.addr) < DEPTH);
	end

	////////////////////////////////////////////////////
	// Read stage

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			tag_game <= 1'b0;
			tag_copy <= 1'b0;
		end else begin
			tag_game <= game_q.req;
			tag_copy <= copy_issue;
		end
	end

	always_comb begin
		game_rsp.ready = tag_game;
		game_rsp.rdata = mem_rdata;
		copy_rsp.ready = tag_copy;
		copy_rsp.rdata = mem_rdata;
	end

endmodule

/* source/sector_buffer.sv */
/*
 * One-sector true dual-port buffer, copy engine and disk side
 */

`timescale 1ns/100ps

module sector_buffer (
	input  logic                          clk_sys,
	input  backup_pkg::buf_port_t         a_port,
	output logic [backup_pkg::WORD_W-1:0] a_rdata,
	input  backup_pkg::buf_port_t         b_port,
	output logic [backup_pkg::WORD_W-1:0] b_rdata
);

	logic [backup_pkg::WORD_W-1:0] words [backup_pkg::SECTOR_WORDS];

	// Both sides write on the edge
	always_ff @(posedge clk_sys) begin
		if (a_port.wr) begin
			words[a_port.addr] <= a_port.data;
		end
		if (b_port.wr) begin
			words[b_port.addr] <= b_port.data;
		end
	end

	// Reads are asynchronous at either port
	assign a_rdata = words[a_port.addr];
	assign b_rdata = words[b_port.addr];

endmodule

/* source/sector_copy.sv */
/*
 * Sector copy engine between save RAM and sector buffer,
 * one memory request per word, both directions
 */

`timescale 1ns/100ps

module sector_copy (
	input  logic                            clk_sys,
	input  logic                            rst,
	input  logic                            copy_start,
	input  logic                            to_memory,
	input  logic [backup_pkg::SECTOR_W-1:0] sector,
	output logic                            copy_done,
	output backup_pkg::mem_req_t            mem_req,
	input  backup_pkg::mem_rsp_t            mem_rsp,
	output backup_pkg::buf_port_t           buf_port,
	input  logic [backup_pkg::WORD_W-1:0]   buf_rdata
);

	backup_pkg::copy_state_e                state_q;
	logic [backup_pkg::WORD_ADDR_W-1:0]     idx_q;
	logic [backup_pkg::SECTOR_W-1:0]        sector_q;
	logic                                   dir_q;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state_q <= backup_pkg::CP_IDLE;
		end else begin
			case (state_q)
				backup_pkg::CP_IDLE: begin
					if (copy_start) begin
						state_q  <= backup_pkg::CP_REQ;
						idx_q    <= '0;
						sector_q <= sector;
						dir_q    <= to_memory;
					end
				end
				backup_pkg::CP_REQ: begin
					state_q <= backup_pkg::CP_WAIT;
				end
				backup_pkg::CP_WAIT: begin
					if (mem_rsp.ready) begin
						if (&idx_q) begin
							state_q <= backup_pkg::CP_DONE;
						end else begin
							idx_q   <= idx_q + 1'b1;
							state_q <= backup_pkg::CP_REQ;
						end
					end
				end
				default: begin
					state_q <= backup_pkg::CP_IDLE;
				end
			endcase
		end
	end

	// Load writes the buffer word, save reads into the buffer
	always_comb begin
		mem_req.req   = (state_q == backup_pkg::CP_REQ);
		mem_req.we    = dir_q;
		mem_req.addr  = {sector_q, idx_q};
		mem_req.wdata = buf_rdata;
	end

	always_comb begin
		buf_port.wr   = (state_q == backup_pkg::CP_WAIT) && mem_rsp.ready && !dir_q;
		buf_port.addr = idx_q;
		buf_port.data = mem_rsp.rdata;
	end

	assign copy_done = (state_q == backup_pkg::CP_DONE);

endmodule

/* source/backup_sequencer.sv */
/*
 * Save size tracking, pending flag, trigger detection
 * and per-sector save and load sequencing
 */

`timescale 1ns/100ps

module backup_sequencer #(
	parameter int MAX_SECTORS = backup_pkg::MAX_SECTORS_DEF
) (
	input  logic                            clk_sys,
	input  logic                            rst,
	input  backup_pkg::ram_type_e           ram_type,
	input  logic                            cart_loaded,
	input  logic                            game_write,
	input  logic                            save_req,
	input  logic                            load_req,
	input  logic                            autosave_en,
	input  logic                            osd_open,
	output backup_pkg::sd_cmd_t             sd_cmd,
	input  logic                            sd_done,
	output logic                            copy_start,
	output logic                            to_memory,
	output logic [backup_pkg::SECTOR_W-1:0] sector,
	input  logic                            copy_done,
	output logic                            save_busy
);

	localparam int CNT_W = $clog2(MAX_SECTORS + 1);

	function automatic logic [CNT_W-1:0] sectors_for(input backup_pkg::ram_type_e rt);
		int n;
		case (rt)
			backup_pkg::RAM_1S: n = 1;
			backup_pkg::RAM_2S: n = 2;
			backup_pkg::RAM_4S: n = 4;
			backup_pkg::RAM_8S: n = 8;
			default:            n = 0;
		endcase
		if (n > MAX_SECTORS) begin
			n = MAX_SECTORS;
		end
		return n[CNT_W-1:0];
	endfunction

	backup_pkg::seq_state_e          state_q;
	logic [CNT_W-1:0]                count_q;
	logic [backup_pkg::SECTOR_W-1:0] sector_q;
	logic                            size_known;
	logic                            pending_q;
	logic                            osd_q;
	logic                            rd_q;
	logic                            wr_q;
	logic                            start_q;
	logic                            dir_q;
	logic                            osd_rise;
	logic                            can_start;
	logic                            start_load;
	logic                            start_save;
	logic                            last_sector;

	////////////////////////////////////////////////////
	// Save size, pending writes, triggers

	assign osd_rise    = osd_open && !osd_q;
	assign can_start   = (state_q == backup_pkg::ST_IDLE) && (count_q != '0);
	assign start_load  = can_start && load_req;
	assign start_save  = can_start && !load_req &&
		(save_req || (osd_rise && autosave_en && pending_q));
	assign last_sector = (int'(sector_q) + 1 == int'(count_q));

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			size_known <= 1'b0;
			count_q    <= '0;
			pending_q  <= 1'b0;
			osd_q      <= 1'b0;
		end else begin
			osd_q <= osd_open;
			// Size comes from the first write after a new cartridge
			if (cart_loaded) begin
				size_known <= 1'b0;
				count_q    <= '0;
			end else if (game_write && !size_known) begin
				size_known <= 1'b1;
				count_q    <= sectors_for(ram_type);
			end
			if (cart_loaded) begin
				pending_q <= 1'b0;
			end else if (game_write) begin
				pending_q <= 1'b1;
			end else if (start_save) begin
				pending_q <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////
	// Sector sequencing

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state_q <= backup_pkg::ST_IDLE;
			rd_q    <= 1'b0;
			wr_q    <= 1'b0;
			start_q <= 1'b0;
		end else begin
			rd_q    <= 1'b0;
			wr_q    <= 1'b0;
			start_q <= 1'b0;
			case (state_q)
				backup_pkg::ST_IDLE: begin
					if (start_load) begin
						state_q  <= backup_pkg::ST_SD_READ;
						rd_q     <= 1'b1;
						sector_q <= '0;
						dir_q    <= 1'b1;
					end else if (start_save) begin
						state_q  <= backup_pkg::ST_COPY_OUT;
						start_q  <= 1'b1;
						sector_q <= '0;
						dir_q    <= 1'b0;
					end
				end
				backup_pkg::ST_SD_READ: begin
					if (sd_done) begin
						state_q <= backup_pkg::ST_COPY_IN;
						start_q <= 1'b1;
					end
				end
				backup_pkg::ST_COPY_IN: begin
					if (copy_done) begin
						if (last_sector) begin
							state_q <= backup_pkg::ST_IDLE;
						end else begin
							sector_q <= sector_q + 1'b1;
							state_q  <= backup_pkg::ST_SD_READ;
							rd_q     <= 1'b1;
						end
					end
				end
				backup_pkg::ST_COPY_OUT: begin
					if (copy_done) begin
						state_q <= backup_pkg::ST_SD_WRITE;
						wr_q    <= 1'b1;
					end
				end
				backup_pkg::ST_SD_WRITE: begin
					if (sd_done) begin
						if (last_sector) begin
							state_q <= backup_pkg::ST_IDLE;
						end else begin
							sector_q <= sector_q + 1'b1;
							state_q  <= backup_pkg::ST_COPY_OUT;
							start_q  <= 1'b1;
						end
					end
				end
				default: begin
					state_q <= backup_pkg::ST_IDLE;
				end
			endcase
		end
	end

	// Sector number doubles as disk LBA
	always_comb begin
		sd_cmd.rd                         = rd_q;
		sd_cmd.wr                         = wr_q;
		sd_cmd.lba                        = '0;
		sd_cmd.lba[backup_pkg::SECTOR_W-1:0] = sector_q;
	end

	assign copy_start = start_q;
	assign to_memory  = dir_q;
	assign sector     = sector_q;
	assign save_busy  = (state_q != backup_pkg::ST_IDLE);

endmodule

/* source/backup_top.sv */
/*
 * Backup RAM save and load engine top level
 */

`timescale 1ns/100ps

module backup_top #(
	parameter int MAX_SECTORS = backup_pkg::MAX_SECTORS_DEF
) (
	input  logic                          clk_sys,
	input  logic                          rst,
	input  backup_pkg::mem_req_t          game_req,
	output backup_pkg::mem_rsp_t          game_rsp,
	input  backup_pkg::ram_type_e         ram_type,
	input  logic                          cart_loaded,
	input  logic                          save_req,
	input  logic                          load_req,
	input  logic                          autosave_en,
	input  logic                          osd_open,
	output backup_pkg::sd_cmd_t           sd_cmd,
	input  logic                          sd_done,
	input  backup_pkg::buf_port_t         sd_buf_in,
	output logic [backup_pkg::WORD_W-1:0] sd_buf_rdata,
	output logic                          save_busy
);

	backup_pkg::mem_req_t            copy_req;
	backup_pkg::mem_rsp_t            copy_rsp;
	backup_pkg::mem_req_t            mem;
	logic [backup_pkg::WORD_W-1:0]   mem_rdata;
	backup_pkg::buf_port_t           buf_a;
	logic [backup_pkg::WORD_W-1:0]   buf_a_rdata;
	logic                            copy_start;
	logic                            copy_done;
	logic                            to_memory;
	logic [backup_pkg::SECTOR_W-1:0] sector;
	logic                            game_write;

	// Any game write marks the save dirty
	assign game_write = game_req.req && game_req.we;

	////////////////////////////////////////////////////
	// Save RAM and its arbiter

	save_memory #(.MAX_SECTORS(MAX_SECTORS)) u_memory (
		.clk_sys (clk_sys),
		.mem     (mem),
		.rdata   (mem_rdata)
	);

	mem_arbiter #(.MAX_SECTORS(MAX_SECTORS)) u_arbiter (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.game_req  (game_req),
		.game_rsp  (game_rsp),
		.copy_req  (copy_req),
		.copy_rsp  (copy_rsp),
		.mem       (mem),
		.mem_rdata (mem_rdata)
	);

	////////////////////////////////////////////////////
	// Sector path

	sector_buffer u_buffer (
		.clk_sys (clk_sys),
		.a_port  (buf_a),
		.a_rdata (buf_a_rdata),
		.b_port  (sd_buf_in),
		.b_rdata (sd_buf_rdata)
	);

	sector_copy u_copy (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.copy_start (copy_start),
		.to_memory  (to_memory),
		.sector     (sector),
		.copy_done  (copy_done),
		.mem_req    (copy_req),
		.mem_rsp    (copy_rsp),
		.buf_port   (buf_a),
		.buf_rdata  (buf_a_rdata)
	);

	backup_sequencer #(.MAX_SECTORS(MAX_SECTORS)) u_seq (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.ram_type    (ram_type),
		.cart_loaded (cart_loaded),
		.game_write  (game_write),
		.save_req    (save_req),
		.load_req    (load_req),
		.autosave_en (autosave_en),
		.osd_open    (osd_open),
		.sd_cmd      (sd_cmd),
		.sd_done     (sd_done),
		.copy_start  (copy_start),
		.to_memory   (to_memory),
		.sector      (sector),
		.copy_done   (copy_done),
		.save_busy   (save_busy)
	);

endmodule

/* tests/backup_sva.sv */
/*
 * Bound checks on the save engine top level ports
 */

`timescale 1ns/100ps

module backup_sva (
	input logic                 clk_sys,
	input logic                 rst,
	input backup_pkg::mem_req_t game_req,
	input backup_pkg::mem_rsp_t game_rsp,
	input logic                 save_req,
	input logic                 load_req,
	input logic                 autosave_en,
	input logic                 osd_open,
	input backup_pkg::sd_cmd_t  sd_cmd,
	input logic                 save_busy
);

	int fail_count = 0;

	// Reset leaves every response and strobe low
	a_reset_quiet: assert property (@(posedge clk_sys)
		rst |=> !game_rsp.ready && !sd_cmd.rd && !sd_cmd.wr && !save_busy)
		else begin $error("outputs not idle after reset"); fail_count++; end

	// Game port answers exactly two cycles after its request
	a_game_latency: assert property (@(posedge clk_sys) disable iff (rst)
		game_req.req |-> ##2 game_rsp.ready)
		else begin $error("game ready missing two cycles after req"); fail_count++; end

	a_game_owner: assert property (@(posedge clk_sys) disable iff (rst)
		game_rsp.ready |-> $past(game_req.req, 2))
		else begin $error("game ready without a game req"); fail_count++; end

	////////////////////////////////////////////////////
	// SD command and busy

	a_sd_in_busy: assert property (@(posedge clk_sys) disable iff (rst)
		(sd_cmd.rd || sd_cmd.wr) |-> save_busy && !(sd_cmd.rd && sd_cmd.wr))
		else begin $error("SD strobe outside a transfer"); fail_count++; end

	a_sd_single: assert property (@(posedge clk_sys) disable iff (rst)
		(sd_cmd.rd || sd_cmd.wr) |=> !(sd_cmd.rd || sd_cmd.wr))
		else begin $error("SD strobe longer than one cycle"); fail_count++; end

	// Busy only follows a trigger one cycle earlier
	a_busy_start: assert property (@(posedge clk_sys) disable iff (rst)
		$rose(save_busy) |-> $past(save_req || load_req || osd_open))
		else begin $error("busy rose without a trigger"); fail_count++; end

	// Menu opening with autosave off starts nothing
	a_autosave_off: assert property (@(posedge clk_sys) disable iff (rst)
		$rose(osd_open) && !autosave_en && !save_req && !load_req && !save_busy
		|=> !save_busy)
		else begin $error("autosave ran while disabled"); fail_count++; end

endmodule

bind backup_top backup_sva u_sva (
	.clk_sys     (clk_sys),
	.rst         (rst),
	.game_req    (game_req),
	.game_rsp    (game_rsp),
	.save_req    (save_req),
	.load_req    (load_req),
	.autosave_en (autosave_en),
	.osd_open    (osd_open),
	.sd_cmd      (sd_cmd),
	.save_busy   (save_busy)
);

/* tests/tb_backup.sv */
/*
 * Save engine testbench, clock and reset, game port and SD disk model,
 * save, load and autosave sequences with a closing result line
 */

`timescale 1ns/100ps

module tb_backup;

	localparam int SECTORS = 4;
	localparam int WORDS   = SECTORS * backup_pkg::SECTOR_WORDS;
	localparam int TRIG_SAVE = 0;
	localparam int TRIG_LOAD = 1;
	localparam int TRIG_CART = 2;

	logic                  clk_sys = 1'b0;
	logic                  rst;
	backup_pkg::mem_req_t  game_req;
	backup_pkg::mem_rsp_t  game_rsp;
	backup_pkg::ram_type_e ram_type;
	logic                  cart_loaded;
	logic                  save_req;
	logic                  load_req;
	logic                  autosave_en;
	logic                  osd_open;
	backup_pkg::sd_cmd_t   sd_cmd;
	logic                  sd_done;
	backup_pkg::buf_port_t sd_buf_in;
	logic [15:0]           sd_buf_rdata;
	logic                  save_busy;

	logic [15:0] disk [8][256];
	logic [15:0] shadow [WORDS];
	int          wr_log [$];
	int          rd_log [$];
	integer      seed = 32'haa97_bd2a;
	int          errors = 0;

	always #2 clk_sys = ~clk_sys;

	backup_top #(.MAX_SECTORS(backup_pkg::MAX_SECTORS_DEF)) u_dut (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.game_req     (game_req),
		.game_rsp     (game_rsp),
		.ram_type     (ram_type),
		.cart_loaded  (cart_loaded),
		.save_req     (save_req),
		.load_req     (load_req),
		.autosave_en  (autosave_en),
		.osd_open     (osd_open),
		.sd_cmd       (sd_cmd),
		.sd_done      (sd_done),
		.sd_buf_in    (sd_buf_in),
		.sd_buf_rdata (sd_buf_rdata),
		.save_busy    (save_busy)
	);

	////////////////////////////////////////////////////
	// Disk model serving one sector per strobe after a random delay

	initial begin
		int     dly;
		int     lba;
		logic   is_wr;
		integer rnd;
		sd_done   = 1'b0;
		sd_buf_in = '0;
		forever begin
			@(negedge clk_sys);
			if (sd_cmd.rd || sd_cmd.wr) begin
				lba   = int'(sd_cmd.lba) % 8;
				is_wr = sd_cmd.wr;
				if (is_wr) wr_log.push_back(int'(sd_cmd.lba));
				else rd_log.push_back(int'(sd_cmd.lba));
				rnd = $random(seed);
				dly = 10 + ((rnd & 32'h7fff_ffff) % 31);
				repeat (dly) @(negedge clk_sys);
				for (int i = 0; i < 256; i++) begin
					@(negedge clk_sys);
					sd_buf_in.addr = 8'(i);
					sd_buf_in.wr   = !is_wr;
					sd_buf_in.data = disk[lba][i];
					if (is_wr) begin
						#1 disk[lba][i] = sd_buf_rdata;
					end
				end
				@(negedge clk_sys);
				sd_buf_in.wr = 1'b0;
				sd_done      = 1'b1;
				@(negedge clk_sys);
				sd_done = 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////
	// Helpers

	task automatic report_error(input string msg);
		errors++;
		$display("** Error at %0t ns: %s", $time, msg);
	endtask

	task automatic abort_run(input string what);
		$display("Timed out waiting for %s at %0t ns", what, $time);
		$display("*** TEST FAILED ***");
		$finish;
	endtask

	task automatic game_access(input logic we, input int addr, input logic [15:0] wdata,
			output logic [15:0] rdata);
		int n;
		@(negedge clk_sys);
		game_req.req   = 1'b1;
		game_req.we    = we;
		game_req.addr  = addr[backup_pkg::MEM_ADDR_W-1:0];
		game_req.wdata = wdata;
		@(negedge clk_sys);
		game_req.req = 1'b0;
		n = 0;
		while (!game_rsp.ready && n < 8) begin
			@(negedge clk_sys);
			n++;
		end
		if (!game_rsp.ready) abort_run("game ready");
		rdata = game_rsp.rdata;
	endtask

	task automatic read_and_compare(input int addr, input logic [15:0] expected);
		logic [15:0] rd;
		game_access(1'b0, addr, '0, rd);
		if (rd !== expected)
			report_error($sformatf("read 0x%03h gave 0x%04h, expected 0x%04h",
				addr, rd, expected));
	endtask

	task automatic pulse_trigger(input int which);
		@(negedge clk_sys);
		case (which)
			TRIG_SAVE: save_req = 1'b1;
			TRIG_LOAD: load_req = 1'b1;
			default:   cart_loaded = 1'b1;
		endcase
		@(negedge clk_sys);
		save_req    = 1'b0;
		load_req    = 1'b0;
		cart_loaded = 1'b0;
	endtask

	task automatic wait_busy(input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (save_busy !== level && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (save_busy !== level) abort_run(what);
	endtask

	task automatic expect_no_start(input string what);
		repeat (8) begin
			@(negedge clk_sys);
			if (save_busy) report_error({"transfer started on ", what});
		end
		if (wr_log.size() + rd_log.size() != 0) report_error({"SD strobe on ", what});
	endtask

	// Strobes must walk sectors 0 to n-1 in one direction
	task automatic check_strobes(input logic is_write, input int n);
		int other;
		int seen;
		other = is_write ? rd_log.size() : wr_log.size();
		seen  = is_write ? wr_log.size() : rd_log.size();
		if (other != 0) report_error("SD strobe in the wrong direction");
		if (seen != n) begin
			report_error($sformatf("expected %0d SD strobes, saw %0d", n, seen));
		end else begin
			for (int i = 0; i < n; i++) begin
				if ((is_write ? wr_log[i] : rd_log[i]) != i)
					report_error($sformatf("strobe %0d has the wrong lba", i));
			end
		end
		wr_log.delete();
		rd_log.delete();
	endtask

	task automatic check_disk();
		for (int a = 0; a < WORDS; a++) begin
			if (disk[a / 256][a % 256] !== shadow[a])
				report_error($sformatf("disk word %0d:%0d is 0x%04h, expected 0x%04h",
					a / 256, a % 256, disk[a / 256][a % 256], shadow[a]));
		end
	endtask

	////////////////////////////////////////////////////
	// Stimulus

	initial begin
		logic [15:0] rd;
		logic [15:0] data;
		int          n;
		int          raddr;
		int          sva_fails;
		rst = 1'b1;
		game_req = '0;
		ram_type = backup_pkg::RAM_4S;
		cart_loaded = 1'b0;
		save_req = 1'b0;
		load_req = 1'b0;
		autosave_en = 1'b0;
		osd_open = 1'b0;
		for (int a = 0; a < 8 * 256; a++) disk[a / 256][a % 256] = 16'h5a00 ^ 16'(a * 7);
		repeat (4) @(negedge clk_sys);
		rst = 1'b0;
		repeat (4) @(negedge clk_sys);

		// Single write and read back
		data = 16'($random(seed));
		game_access(1'b1, 5, data, rd);
		read_and_compare(5, data);

		// New cartridge leaves the size unknown until the first write
		pulse_trigger(TRIG_CART);
		pulse_trigger(TRIG_SAVE);
		expect_no_start("save before any write");
		pulse_trigger(TRIG_LOAD);
		expect_no_start("load before any write");

		for (int a = 0; a < WORDS; a++) begin
			shadow[a] = 16'($random(seed));
			game_access(1'b1, a, shadow[a], rd);
		end
		pulse_trigger(TRIG_SAVE);
		wait_busy(1'b1, 4, "save start");
		wait_busy(1'b0, 20000, "save end");
		check_strobes(1'b1, SECTORS);
		check_disk();

		// Game reads while a second save runs
		for (int a = 0; a < 8 * 256; a++) disk[a / 256][a % 256] = 16'h0f0f ^ 16'(a * 13);
		pulse_trigger(TRIG_SAVE);
		wait_busy(1'b1, 4, "save start");
		n = 0;
		while (save_busy && n < 5000) begin
			raddr = ($random(seed) & 32'h7fff_ffff) % WORDS;
			read_and_compare(raddr, shadow[raddr]);
			n++;
		end
		wait_busy(1'b0, 20000, "save end");
		check_strobes(1'b1, SECTORS);
		check_disk();

		// Load a fresh disk pattern
		for (int a = 0; a < 8 * 256; a++) disk[a / 256][a % 256] = 16'($random(seed));
		pulse_trigger(TRIG_LOAD);
		wait_busy(1'b1, 4, "load start");
		wait_busy(1'b0, 20000, "load end");
		check_strobes(1'b0, SECTORS);
		for (int a = 0; a < WORDS; a++) begin
			shadow[a] = disk[a / 256][a % 256];
			read_and_compare(a, shadow[a]);
		end

		// Autosave on menu open
		autosave_en = 1'b1;
		shadow[17] = 16'($random(seed));
		game_access(1'b1, 17, shadow[17], rd);
		@(negedge clk_sys) osd_open = 1'b1;
		wait_busy(1'b1, 4, "autosave start");
		wait_busy(1'b0, 20000, "autosave end");
		check_strobes(1'b1, SECTORS);
		check_disk();
		@(negedge clk_sys) osd_open = 1'b0;
		@(negedge clk_sys) osd_open = 1'b1;
		expect_no_start("menu open with nothing pending");
		@(negedge clk_sys) osd_open = 1'b0;
		autosave_en = 1'b0;
		game_access(1'b1, 18, 16'($random(seed)), rd);
		@(negedge clk_sys) osd_open = 1'b1;
		expect_no_start("menu open with autosave off");
		@(negedge clk_sys) osd_open = 1'b0;
		repeat (4) @(negedge clk_sys);

		sva_fails = u_dut.u_sva.fail_count;
		$display("Result: %0d model errors, %0d assertion failures", errors, sva_fails);
		if (errors == 0 && sva_fails == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* filelist.f */
source/backup_pkg.sv
source/save_memory.sv
source/mem_arbiter.sv
source/sector_buffer.sv
source/sector_copy.sv
source/backup_sequencer.sv
source/backup_top.sv
tests/backup_sva.sv
tests/tb_backup.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the save engine testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_backup \
	-f filelist.f -o tb_backup \
	&& ./obj_dir/tb_backup +verilator+error+limit+1000 | tee sim.log \
	&& grep -q "\*\*\* TEST PASSED \*\*\*" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
